/* source/lfsr_pkg.sv */
// LFSR counter definitions
// Width limits, the primitive polynomial tap table and the per-channel
// control word that the command decoder hands to each counter

package lfsr_pkg;

	localparam int MAX_WIDTH = 32; // Tap table range ends here
	localparam int MAX_CH    = 16; // Bound by the 16-bit mask fields

	// ----------------------------------------
	// Per-channel control
	// ----------------------------------------
	typedef struct packed {
		logic load_n; // Active low, takes load_data
		logic cen;    // Active high, register updates
	} ch_ctrl_t;

	// ----------------------------------------
	// Feedback taps
	// ----------------------------------------
	// Bit 0 is always part of the feedback, the other set bits mark
	// the extra tapped stages of the right-shifting register
	function automatic logic [MAX_WIDTH-1:0] lfsr_taps(input int width);
		case (width)
			2:       return 32'h0000_0003;
			3:       return 32'h0000_0003;
			4:       return 32'h0000_0003;
			5:       return 32'h0000_0005;
			6:       return 32'h0000_0003;
			7:       return 32'h0000_0003;
			8:       return 32'h0000_0063;
			9:       return 32'h0000_0011;
			10:      return 32'h0000_0009;
			11:      return 32'h0000_0005;
			12:      return 32'h0000_0099;
			13:      return 32'h0000_001b;
			14:      return 32'h0000_1803;
			15:      return 32'h0000_0003;
			16:      return 32'h0000_002d;
			17:      return 32'h0000_0009;
			18:      return 32'h0000_0081;
			19:      return 32'h0000_0063;
			20:      return 32'h0000_0009;
			21:      return 32'h0000_0005;
			22:      return 32'h0000_0003;
			23:      return 32'h0000_0021;
			24:      return 32'h0000_001b;
			25:      return 32'h0000_0009;
			26:      return 32'h0000_0183;
			27:      return 32'h0000_0183;
			28:      return 32'h0000_0009;
			29:      return 32'h0000_0005;
			30:      return 32'h0001_8003;
			31:      return 32'h0000_0009;
			32:      return 32'h1800_0003;
			default: return '0; // Unsupported width
		endcase
	endfunction

endpackage

/* source/cmd_pkg.sv */
// Host command definitions
// Opcodes and the 38-bit command word, seen either as a channel load
// or as an enable and clear control word

package cmd_pkg;

	typedef enum logic [1:0] {
		OP_NOP     = 2'd0,
		OP_LOAD    = 2'd1,
		OP_CONTROL = 2'd2
	} cmd_op_e;

	// ----------------------------------------
	// Load view
	// ----------------------------------------
	typedef struct packed {
		cmd_op_e                              op;
		logic [$clog2(lfsr_pkg::MAX_CH)-1:0]  ch;   // Target channel
		logic [lfsr_pkg::MAX_WIDTH-1:0]       seed; // Low WIDTH bits used
	} cmd_load_t;

	// ----------------------------------------
	// Control view
	// ----------------------------------------
	typedef struct packed {
		cmd_op_e                     op;
		logic [lfsr_pkg::MAX_CH-1:0] en_mask;  // New enable set
		logic [lfsr_pkg::MAX_CH-1:0] clr_mask; // Hit flags to drop
		logic [3:0]                  pad;
	} cmd_ctrl_t;

	// Opcode sits at the top in both views
	typedef union packed {
		cmd_load_t load;
		cmd_ctrl_t ctrl;
	} cmd_word_t;

endpackage

/* source/lfsr_cmd_decoder.sv */
// Command decoder for the LFSR timer bank
// Turns single-strobe host commands into registered per-channel load
// pulses, the enable register and one-cycle hit clear pulses

module lfsr_cmd_decoder #(
	parameter int WIDTH  = 8,
	parameter int NUM_CH = 4
) (
	input  logic                              clk,
	input  logic                              reset,
	input  cmd_pkg::cmd_word_t                cmd,
	input  logic                              cmd_valid,
	output lfsr_pkg::ch_ctrl_t [NUM_CH-1:0]   ch_ctrl,
	output logic [WIDTH-1:0]                  load_data,
	output logic [NUM_CH-1:0]                 clear
);

	cmd_pkg::cmd_op_e   op;
	logic               is_load;
	logic               is_ctrl;
	logic [NUM_CH-1:0]  load_sel;
	logic [NUM_CH-1:0]  load_q;   // One-hot load pulse
	logic [NUM_CH-1:0]  en_q;     // Enable register
	logic [NUM_CH-1:0]  clear_q;
	logic [WIDTH-1:0]   data_q;

	assign op      = cmd.load.op; // Same bits in the control view
	assign is_load = cmd_valid && (op == cmd_pkg::OP_LOAD);
	assign is_ctrl = cmd_valid && (op == cmd_pkg::OP_CONTROL);

	// Channels at or above NUM_CH match nothing, so such loads vanish
	always_comb
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			load_sel[i] = (cmd.load.ch == 4'(i));
		end
	end

	// ----------------------------------------
	// Control registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			load_q  <= '0;
			en_q    <= '0;
			clear_q <= '0;
		end
		else
		begin
			load_q  <= is_load ? load_sel : '0;
			clear_q <= is_ctrl ? cmd.ctrl.clr_mask[NUM_CH-1:0] : '0;
			if (is_ctrl)
				en_q <= cmd.ctrl.en_mask[NUM_CH-1:0];
		end
	end

	// Seed is shared by all channels
	always_ff @(posedge clk)
	begin
		if (is_load)
			data_q <= cmd.load.seed[WIDTH-1:0];
	end

	// A load forces cen for its cycle regardless of the enable bit
	always_comb
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			ch_ctrl[i].load_n = ~load_q[i];
			ch_ctrl[i].cen    = en_q[i] | load_q[i];
		end
	end

	assign load_data = data_q;
	assign clear     = clear_q;

endmodule

/* source/lfsr_counter.sv */
// Loadable LFSR counter
// Right-shifting register with XNOR feedback from a primitive
// polynomial, plus a static flag while the count equals COUNT_TO

module lfsr_counter #(
	parameter int WIDTH    = 8,
	parameter int COUNT_TO = 37
) (
	input  logic                clk,
	input  logic                reset,
	input  lfsr_pkg::ch_ctrl_t  ctrl,
	input  logic [WIDTH-1:0]    data,
	output logic [WIDTH-1:0]    count,
	output logic                tercnt
);

	localparam logic [WIDTH-1:0] TAPS = WIDTH'(lfsr_pkg::lfsr_taps(WIDTH));

	logic [WIDTH-1:0] cnt_q;
	logic [WIDTH-1:0] cnt_step;
	logic [WIDTH-1:0] cnt_d;
	logic             fb;

	// Next state
	always_comb
	begin
		fb       = ^(cnt_q & TAPS); // Bit 0 always tapped
		cnt_step = {~fb, cnt_q[WIDTH-1:1]};
		cnt_d    = ctrl.load_n ? cnt_step : data;
	end

	// Loads only land when cen is high too
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			cnt_q <= '0;
		else if (ctrl.cen)
			cnt_q <= cnt_d;
	end

	assign tercnt = (cnt_q == WIDTH'(COUNT_TO));
	assign count  = cnt_q;

endmodule

/* source/terminal_collector.sv */
// Terminal count collector
// Sticky per-channel hit flags with clear by mask, a registered
// interrupt level and the number of the lowest pending channel

module terminal_collector #(
	parameter int NUM_CH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [NUM_CH-1:0] tercnt,
	input  logic [NUM_CH-1:0] clear,
	output logic [NUM_CH-1:0] hit,
	output logic              irq,
	output logic [3:0]        irq_ch
);

	logic [NUM_CH-1:0] hit_q;
	logic              irq_q;

	// ----------------------------------------
	// Sticky flags and interrupt
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			hit_q <= '0;
			irq_q <= 1'b0;
		end
		else
		begin
			hit_q <= (hit_q & ~clear) | tercnt; // Set beats clear
			irq_q <= |hit_q;
		end
	end

	// Lowest pending channel wins
	always_comb
	begin
		irq_ch = '0;
		for (int i = NUM_CH - 1; i >= 0; i--)
		begin
			if (hit_q[i])
				irq_ch = 4'(i);
		end
	end

	assign hit = hit_q;
	assign irq = irq_q;

endmodule

/* source/lfsr_timer_bank.sv */
// LFSR timer bank, top level
// Command decoder, an array of NUM_CH LFSR counters and the terminal
// count collector that raises the interrupt

module lfsr_timer_bank #(
	parameter int WIDTH    = 8,
	parameter int NUM_CH   = 4,
	parameter int COUNT_TO = 37
) (
	input  logic                          clk,
	input  logic                          reset,
	input  cmd_pkg::cmd_word_t            cmd,
	input  logic                          cmd_valid,
	output logic [NUM_CH-1:0][WIDTH-1:0]  count,
	output logic [NUM_CH-1:0]             tercnt,
	output logic [NUM_CH-1:0]             hit,
	output logic                          irq,
	output logic [3:0]                    irq_ch
);

	lfsr_pkg::ch_ctrl_t [NUM_CH-1:0] ch_ctrl;
	logic [WIDTH-1:0]                load_data;
	logic [NUM_CH-1:0]               clear;

	lfsr_cmd_decoder #(
		.WIDTH  (WIDTH),
		.NUM_CH (NUM_CH)
	) u_decoder (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.ch_ctrl   (ch_ctrl),
		.load_data (load_data),
		.clear     (clear)
	);

	// ----------------------------------------
	// Counter array
	// ----------------------------------------
	for (genvar i = 0; i < NUM_CH; i++)
	begin : g_ch
		lfsr_counter #(
			.WIDTH    (WIDTH),
			.COUNT_TO (COUNT_TO)
		) u_counter (
			.clk    (clk),
			.reset  (reset),
			.ctrl   (ch_ctrl[i]),
			.data   (load_data), // Shared seed bus
			.count  (count[i]),
			.tercnt (tercnt[i])
		);
	end

	terminal_collector #(
		.NUM_CH (NUM_CH)
	) u_collector (
		.clk    (clk),
		.reset  (reset),
		.tercnt (tercnt),
		.clear  (clear),
		.hit    (hit),
		.irq    (irq),
		.irq_ch (irq_ch)
	);

endmodule

/* verif/lfsr_timer_bank_asserts.sv */
// Protocol checks for the LFSR timer bank
// Load pulse shape, interrupt timing and sticky hit behavior

module lfsr_timer_bank_asserts #(
	parameter int NUM_CH = 4
) (
	input logic                            clk,
	input logic                            reset,
	input lfsr_pkg::ch_ctrl_t [NUM_CH-1:0] ch_ctrl,
	input logic [NUM_CH-1:0]               clear,
	input logic [NUM_CH-1:0]               hit,
	input logic                            irq
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [NUM_CH-1:0] load_n;
	logic [NUM_CH-1:0] cen;

	always_comb
	begin
		for (int i = 0; i < NUM_CH; i++)
		begin
			load_n[i] = ch_ctrl[i].load_n;
			cen[i]    = ch_ctrl[i].cen;
		end
	end

	load_has_cen: assert property (@(posedge clk) disable iff (!reset)
		(~load_n & ~cen) == '0)
		else $error("Load pulse without count enable");

	single_load: assert property (@(posedge clk) disable iff (!reset)
		$onehot0(~load_n))
		else $error("More than one channel loading");

	irq_follows_hit: assert property (@(posedge clk) disable iff (!reset)
		irq == $past(|hit))
		else $error("Interrupt does not follow the hit flags");

	// A flag only drops after its clear pulse
	hit_sticky: assert property (@(posedge clk) disable iff (!reset)
		($past(hit) & ~hit & ~$past(clear)) == '0)
		else $error("Hit flag fell without a clear pulse");

endmodule

bind lfsr_timer_bank lfsr_timer_bank_asserts #(
	.NUM_CH (NUM_CH)
) u_asserts (
	.clk     (clk),
	.reset   (reset),
	.ch_ctrl (ch_ctrl),
	.clear   (clear),
	.hit     (hit),
	.irq     (irq)
);

/* verif/tb_lfsr_timer_bank.sv */
// Testbench for the LFSR timer bank
// Drives load, control and random command traffic, keeps a cycle model
// of every channel and compares counts, flags and the interrupt

module tb_lfsr_timer_bank;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WIDTH    = 8;
	localparam int NUM_CH   = 4;
	localparam int COUNT_TO = 37;

	// x^8 + x^6 + x^5 + x + 1, feedback from stages 0, 1, 5 and 6
	localparam logic [WIDTH-1:0] REF_TAPS = 8'b0110_0011;

	logic                         clk;
	logic                         reset;
	cmd_pkg::cmd_word_t           cmd;
	logic                         cmd_valid;
	logic [NUM_CH-1:0][WIDTH-1:0] count;
	logic [NUM_CH-1:0]            tercnt;
	logic [NUM_CH-1:0]            hit;
	logic                         irq;
	logic [3:0]                   irq_ch;

	// Model state
	logic [WIDTH-1:0]  m_count [NUM_CH];
	logic [NUM_CH-1:0] m_en;
	logic [NUM_CH-1:0] m_load;  // Load pulse due at the next edge
	logic [NUM_CH-1:0] m_clear;
	logic [NUM_CH-1:0] m_hit;
	logic              m_irq;
	logic [WIDTH-1:0]  m_data;

	int unsigned err_count;
	int unsigned timeout_count;
	logic [31:0] rng_state;

	lfsr_timer_bank #(
		.WIDTH    (WIDTH),
		.NUM_CH   (NUM_CH),
		.COUNT_TO (COUNT_TO)
	) lfsr_timer_bank_inst (
		.clk       (clk),
		.reset     (reset),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.count     (count),
		.tercnt    (tercnt),
		.hit       (hit),
		.irq       (irq),
		.irq_ch    (irq_ch)
	);

	always #4 clk = ~clk;

	// ----------------------------------------
	// Reference functions
	// ----------------------------------------
	function automatic logic [WIDTH-1:0] lfsr_ref_next(input logic [WIDTH-1:0] cur);
		logic fb;
		fb = 1'b0;
		for (int b = 0; b < WIDTH; b++)
		begin
			if (REF_TAPS[b])
				fb = fb ^ cur[b];
		end
		return {~fb, cur[WIDTH-1:1]};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [3:0] lowest_pending(input logic [NUM_CH-1:0] flags);
		for (int i = 0; i < NUM_CH; i++)
		begin
			if (flags[i])
				return 4'(i);
		end
		return 4'd0;
	endfunction

	function automatic logic [NUM_CH-1:0] model_tercnt();
		logic [NUM_CH-1:0] t;
		for (int i = 0; i < NUM_CH; i++)
			t[i] = (m_count[i] == WIDTH'(COUNT_TO));
		return t;
	endfunction

	function automatic cmd_pkg::cmd_word_t load_word(input logic [3:0] ch,
		input logic [31:0] seed);
		cmd_pkg::cmd_word_t w;
		w.load.op   = cmd_pkg::OP_LOAD;
		w.load.ch   = ch;
		w.load.seed = seed;
		return w;
	endfunction

	function automatic cmd_pkg::cmd_word_t ctrl_word(input logic [15:0] en,
		input logic [15:0] clr);
		cmd_pkg::cmd_word_t w;
		w.ctrl.op       = cmd_pkg::OP_CONTROL;
		w.ctrl.en_mask  = en;
		w.ctrl.clr_mask = clr;
		w.ctrl.pad      = '0;
		return w;
	endfunction

	// ----------------------------------------
	// Cycle model
	// ----------------------------------------
	always @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < NUM_CH; i++)
				m_count[i] = '0;
			m_en    = '0;
			m_load  = '0;
			m_clear = '0;
			m_hit   = '0;
			m_irq   = 1'b0;
			m_data  = '0;
		end
		else
		begin
			m_irq = |m_hit;                              // Old flags
			m_hit = (m_hit & ~m_clear) | model_tercnt(); // Set beats clear
			for (int i = 0; i < NUM_CH; i++)
			begin
				if (m_load[i])
					m_count[i] = m_data;
				else if (m_en[i])
					m_count[i] = lfsr_ref_next(m_count[i]);
			end
			// Command sampled at this edge
			m_load  = '0;
			m_clear = '0;
			if (cmd_valid && cmd.load.op == cmd_pkg::OP_LOAD)
			begin
				m_data = cmd.load.seed[WIDTH-1:0];
				if (int'(cmd.load.ch) < NUM_CH)
					m_load = NUM_CH'(1) << cmd.load.ch;
			end
			else if (cmd_valid && cmd.ctrl.op == cmd_pkg::OP_CONTROL)
			begin
				m_en    = cmd.ctrl.en_mask[NUM_CH-1:0];
				m_clear = cmd.ctrl.clr_mask[NUM_CH-1:0];
			end
		end
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_count(input int ch, input logic [WIDTH-1:0] got,
		input logic [WIDTH-1:0] exp);
		if (got !== exp)
		begin
			err_count++;
			$display("FAILED at %0t: count[%0d] is %0h, expected %0h", $time, ch, got, exp);
		end
	endtask

	task automatic check_hits(input string what, input logic [NUM_CH-1:0] got,
		input logic [NUM_CH-1:0] exp);
		if (got !== exp)
		begin
			err_count++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_irq(input logic got_irq, input logic [3:0] got_ch,
		input logic exp_irq, input logic [3:0] exp_ch);
		if (got_irq !== exp_irq || got_ch !== exp_ch)
		begin
			err_count++;
			$display("FAILED at %0t: irq %b ch %0d, expected irq %b ch %0d",
				$time, got_irq, got_ch, exp_irq, exp_ch);
		end
	endtask

	// Outputs are settled mid-cycle
	always @(negedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_CH; i++)
				check_count(i, count[i], m_count[i]);
			check_hits("tercnt", tercnt, model_tercnt());
			check_hits("hit", hit, m_hit);
			check_irq(irq, irq_ch, m_irq, lowest_pending(m_hit));
		end
	end

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------
	task automatic drive(input logic valid, input cmd_pkg::cmd_word_t word);
		@(posedge clk);
		#1;
		cmd_valid = valid;
		cmd       = word;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive(1'b0, '0);
	endtask

	task automatic wait_count(input int ch, input logic [WIDTH-1:0] value, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (count[ch] !== value && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (count[ch] !== value)
		begin
			timeout_count++;
			$display("Timeout: channel %0d never reached count %0h", ch, value);
		end
	endtask

	task automatic wait_hit(input int ch, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (hit[ch] !== 1'b1 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (hit[ch] !== 1'b1)
		begin
			timeout_count++;
			$display("Timeout: hit flag of channel %0d never rose", ch);
		end
	endtask

	task automatic wait_irq(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (irq !== 1'b1 && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (irq !== 1'b1)
		begin
			timeout_count++;
			$display("Timeout: interrupt never rose");
		end
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		logic [WIDTH-1:0] probe;
		logic [WIDTH-1:0] near_seed;
		logic [31:0]      r;
		int               period;

		clk           = 1'b0;
		reset         = 1'b0;
		cmd           = '0;
		cmd_valid     = 1'b0;
		err_count     = 0;
		timeout_count = 0;
		rng_state     = 32'd61218;

		// The reference sequence from zero must be maximal length
		probe  = lfsr_ref_next('0);
		period = 1;
		while (probe != '0 && period < 1000)
		begin
			probe = lfsr_ref_next(probe);
			period++;
		end
		if (period != (1 << WIDTH) - 1)
		begin
			err_count++;
			$display("FAILED at %0t: reference period %0d is not maximal", $time, period);
		end

		// Seed three steps short of the terminal value
		near_seed = '0;
		for (int v = 0; v < (1 << WIDTH); v++)
		begin
			probe = lfsr_ref_next(lfsr_ref_next(lfsr_ref_next(WIDTH'(v))));
			if (probe == WIDTH'(COUNT_TO))
				near_seed = WIDTH'(v);
		end

		repeat (16) @(posedge clk);
		#1;
		reset = 1'b1;
		idle(10); // Nothing enabled, counts stay at zero

		// Loads land on disabled channels and are held
		for (int c = 0; c < NUM_CH; c++)
		begin
			drive(1'b1, load_word(4'(c), 32'h11 * (c + 1)));
			drive(1'b0, '0);
			wait_count(c, WIDTH'(32'h11 * (c + 1)), 6);
		end
		idle(5);

		drive(1'b1, ctrl_word(16'h0005, 16'h0000));
		idle(30);
		drive(1'b1, ctrl_word(16'h000a, 16'h0000));
		idle(30);
		drive(1'b1, ctrl_word(16'h0000, 16'h0000));
		idle(5);

		// Terminal count on channel 2, then a lower channel joins
		drive(1'b1, load_word(4'd2, 32'(near_seed)));
		drive(1'b0, '0);
		wait_count(2, near_seed, 6);
		drive(1'b1, ctrl_word(16'h0004, 16'h0000));
		wait_hit(2, 20);
		wait_irq(10);
		drive(1'b1, load_word(4'd1, 32'(near_seed)));
		drive(1'b0, '0);
		wait_count(1, near_seed, 6);
		drive(1'b1, ctrl_word(16'h0006, 16'h0000));
		wait_hit(1, 20);
		drive(1'b1, ctrl_word(16'h0000, 16'h0000));
		idle(4);

		// Clear, and a clear that loses against a live terminal count
		drive(1'b1, ctrl_word(16'h0000, 16'h0004));
		idle(3);
		drive(1'b1, load_word(4'd3, 32'(COUNT_TO)));
		drive(1'b0, '0);
		wait_hit(3, 6);
		drive(1'b1, ctrl_word(16'h0000, 16'h000a));
		idle(3);
		drive(1'b1, load_word(4'd3, 32'h0000_0000));
		idle(3);
		drive(1'b1, ctrl_word(16'h0000, 16'h0008));
		idle(5);

		// Random command mix
		for (int k = 0; k < 2000; k++)
		begin
			rng_state = xorshift(rng_state);
			r         = rng_state;
			rng_state = xorshift(rng_state);
			case (r[2:0])
				3'd3:    drive(1'b1, load_word({2'b00, r[4:3]}, 32'(near_seed)));
				3'd4,
				3'd5:    drive(1'b1, load_word({1'b0, r[5:3]}, rng_state));
				3'd6:    drive(1'b1, ctrl_word(r[31:16], rng_state[15:0]));
				3'd7:    drive(1'b1, '0); // NOP opcode
				default: drive(1'b0, cmd_pkg::cmd_word_t'(38'(rng_state)));
			endcase
		end
		idle(4);

		$display("Checks done: %0d mismatches, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* list.f */
source/lfsr_pkg.sv
source/cmd_pkg.sv
source/lfsr_cmd_decoder.sv
source/lfsr_counter.sv
source/terminal_collector.sv
source/lfsr_timer_bank.sv
verif/lfsr_timer_bank_asserts.sv
verif/tb_lfsr_timer_bank.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, then judge the run from its log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f list.f --top-module tb_lfsr_timer_bank \
	-o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 && cat sim.log || { cat sim.log; echo "Simulation aborted"; exit 1; }
grep -qx "TEST OK" sim.log && echo "Verdict: pass" || { echo "Verdict: fail"; exit 1; }
